//--- include/align_settings.svh
//////////////////////////////
// Sizes for the alignment buffer; depth 3 and two outstanding
// are the only values the throttle and counter widths support
//////////////////////////////

`ifndef ALIGN_SETTINGS_SVH
`define ALIGN_SETTINGS_SVH

// Instruction address width
`define ALIGN_ADDR_W 32

// Words held in the fetch FIFO
// Minimum for two requests in flight plus one dangling parcel
`define ALIGN_FIFO_DEPTH 3

// Fetch requests allowed in flight
`define ALIGN_MAX_OUTSTANDING 2

`endif

//--- source/align_pkg.sv
//////////////////////////////
// Shared types of the alignment buffer
// Counter widths follow the settings header
//////////////////////////////

`include "align_settings.svh"

package align_pkg;

  //////////////////////////////
  // Instruction word views

  // One 16-bit instruction parcel
  typedef logic [15:0] parcel_t;

  // Word split into its two parcels
  // Low parcel sits at the lower halfword address
  typedef struct packed {
    parcel_t hi;
    parcel_t lo;
  } parcel_pair_t;

  // Fetched word, read either whole or as two parcels
  typedef union packed {
    logic [31:0]  instr;
    parcel_pair_t parcel;
  } fetch_word_u;

  //////////////////////////////
  // Counters and pointers

  // Index into the word FIFO
  typedef logic [$clog2(`ALIGN_FIFO_DEPTH)-1:0] fifo_ptr_t;

  // Complete instructions held, one bit more than the word index
  typedef logic [$clog2(`ALIGN_FIFO_DEPTH):0] instr_cnt_t;

  // Requests in flight, also used for words still to flush
  typedef logic [$clog2(`ALIGN_MAX_OUTSTANDING+1)-1:0] outstanding_cnt_t;

endpackage

//--- source/fifo_read_if.sv
//////////////////////////////
// Read side of the word FIFO
// Head and next entry plus the advance strobe
//////////////////////////////

`timescale 1ns/10ps

interface fifo_read_if;

  // Entry at the read pointer
  logic                   head_valid;
  align_pkg::fetch_word_u head_word;
  logic                   head_err;

  // Entry after the read pointer
  logic                   next_valid;
  align_pkg::fetch_word_u next_word;
  logic                   next_err;

  // Head word fully consumed
  logic                   advance;

  // FIFO presents both entries and takes advance
  modport fifo_side (
    output head_valid, head_word, head_err,
    output next_valid, next_word, next_err,
    input  advance
  );

  // Aligner reads both entries and drives advance
  modport aligner_side (
    input  head_valid, head_word, head_err,
    input  next_valid, next_word, next_err,
    output advance
  );

endinterface

//--- source/fetch_ctrl.sv
//////////////////////////////
// Fetch throttle and flush control; valid only for a 3-word
// FIFO and at most 2 requests in flight
//////////////////////////////

`timescale 1ns/10ps

`include "align_settings.svh"

module fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_req_i,
  input  logic                   pc_set_i,
  input  logic                   branch_half_i,
  input  logic                   kill_i,
  input  logic                   fetch_ready_i,
  input  logic                   resp_valid_i,
  input  align_pkg::fetch_word_u resp_rdata_i,
  input  logic                   emit_i,
  output logic                   fetch_valid_o,
  output logic                   busy_o,
  output logic                   resp_keep_o
);

  align_pkg::outstanding_cnt_t outstanding_q, outstanding_d;
  align_pkg::outstanding_cnt_t flush_q, flush_d;
  align_pkg::instr_cnt_t       instr_cnt_q, instr_cnt_d;
  align_pkg::instr_cnt_t       instr_cnt_adj;
  logic                        pop_q;
  logic                        aligned_q, aligned_d;
  logic                        complete_q, complete_d;
  logic [1:0]                  n_incoming;
  logic                        lo_compressed;
  logic                        hi_compressed;
  logic                        req_accept;
  logic                        flush_load;

  // Branch or kill drops whatever is still owed
  assign flush_load = pc_set_i || kill_i;

  // Responses still owed from before a branch are removed here
  assign resp_keep_o = resp_valid_i && (flush_q == '0) && !flush_load;

  //////////////////////////////
  // Request throttle

  // Count corrected by last cycle's take
  assign instr_cnt_adj = instr_cnt_q - align_pkg::instr_cnt_t'(pop_q);

  assign fetch_valid_o = instr_req_i &&
                         (outstanding_q < align_pkg::outstanding_cnt_t'(`ALIGN_MAX_OUTSTANDING)) &&
                         (pc_set_i ||
                          (instr_cnt_adj == '0) ||
                          ((instr_cnt_adj == 'd1) && (outstanding_q == '0)));

  assign req_accept = fetch_valid_o && fetch_ready_i;

  // Busy while anything is owed or asked for
  assign busy_o = (outstanding_q != '0) || fetch_valid_o;

  // Up on accept, down on every response, kept or not
  always_comb begin
    outstanding_d = outstanding_q;
    if (req_accept && !resp_valid_i) begin
      outstanding_d = outstanding_q + 'd1;
    end else if (!req_accept && resp_valid_i) begin
      outstanding_d = outstanding_q - 'd1;
    end
  end

  // One fewer to flush if a response lands in the branch cycle
  always_comb begin
    flush_d = flush_q;
    if (flush_load) begin
      flush_d = outstanding_q - align_pkg::outstanding_cnt_t'(resp_valid_i);
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_d = flush_q - 'd1;
    end
  end

  //////////////////////////////
  // Complete instruction count

  assign lo_compressed = resp_rdata_i.parcel.lo[1:0] != 2'b11;
  assign hi_compressed = resp_rdata_i.parcel.hi[1:0] != 2'b11;

  // Aligned and complete track the write side of the FIFO
  // Unaligned but complete only after an odd branch
  always_comb begin
    aligned_d  = aligned_q;
    complete_d = complete_q;
    n_incoming = 2'd0;
    if (pc_set_i) begin
      aligned_d  = !branch_half_i;
      complete_d = branch_half_i;
    end else if (resp_keep_o) begin
      if (aligned_q && !lo_compressed) begin
        // Whole 32-bit instruction, state unchanged
        n_incoming = 2'd1;
      end else if (!aligned_q && complete_q && !hi_compressed) begin
        // Odd branch target starts a 32-bit instruction
        aligned_d  = 1'b0;
        complete_d = 1'b0;
      end else if (!aligned_q && complete_q) begin
        n_incoming = 2'd1;
        aligned_d  = 1'b1;
      end else if (!hi_compressed) begin
        // Low half finishes something, high half starts a 32-bit one
        n_incoming = 2'd1;
        aligned_d  = 1'b0;
        complete_d = 1'b0;
      end else begin
        n_incoming = 2'd2;
        aligned_d  = 1'b1;
        complete_d = 1'b1;
      end
    end
  end

  // Take is subtracted one cycle late
  always_comb begin
    if (flush_load) begin
      instr_cnt_d = '0;
    end else begin
      instr_cnt_d = instr_cnt_adj + align_pkg::instr_cnt_t'(n_incoming);
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      flush_q       <= '0;
      instr_cnt_q   <= '0;
      pop_q         <= 1'b0;
      aligned_q     <= 1'b0;
      complete_q    <= 1'b0;
    end else begin
      outstanding_q <= outstanding_d;
      flush_q       <= flush_d;
      instr_cnt_q   <= instr_cnt_d;
      pop_q         <= emit_i && !flush_load;
      aligned_q     <= aligned_d;
      complete_q    <= complete_d;
    end
  end

endmodule

//--- source/word_fifo.sv
//////////////////////////////
// Circular word store; no overflow check, the fetch
// throttle keeps it from filling past its depth
//////////////////////////////

`timescale 1ns/10ps

`include "align_settings.svh"

module word_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pc_set_i,
  input  logic                   kill_i,
  input  logic                   resp_keep_i,
  input  align_pkg::fetch_word_u resp_rdata_i,
  input  logic                   resp_err_i,
  fifo_read_if.fifo_side         rd
);

  localparam int unsigned DEPTH = `ALIGN_FIFO_DEPTH;

  align_pkg::fetch_word_u mem_q [DEPTH];
  logic [DEPTH-1:0]       err_q;
  logic [DEPTH-1:0]       valid_q, valid_d;
  align_pkg::fifo_ptr_t   wptr_q;
  align_pkg::fifo_ptr_t   rptr_q;
  align_pkg::fifo_ptr_t   rptr_next;
  logic                   clear;

  // Step a pointer with wrap at the last entry
  function automatic align_pkg::fifo_ptr_t ptr_inc(input align_pkg::fifo_ptr_t ptr);
    if (ptr == align_pkg::fifo_ptr_t'(DEPTH-1)) begin
      return '0;
    end
    return ptr + 'd1;
  endfunction

  // Branch or kill empties the store
  assign clear = pc_set_i || kill_i;

  assign rptr_next = ptr_inc(rptr_q);

  //////////////////////////////
  // Read side

  assign rd.head_valid = valid_q[rptr_q];
  assign rd.head_word  = mem_q[rptr_q];
  assign rd.head_err   = err_q[rptr_q];
  assign rd.next_valid = valid_q[rptr_next];
  assign rd.next_word  = mem_q[rptr_next];
  assign rd.next_err   = err_q[rptr_next];

  // Write sets its bit before advance clears the head
  // A bypassed word written and consumed in one cycle ends up empty
  always_comb begin
    valid_d = valid_q;
    if (resp_keep_i) begin
      valid_d[wptr_q] = 1'b1;
    end
    if (rd.advance) begin
      valid_d[rptr_q] = 1'b0;
    end
  end

  // Payload store
  always_ff @(posedge clk) begin
    if (resp_keep_i) begin
      mem_q[wptr_q] <= resp_rdata_i;
      err_q[wptr_q] <= resp_err_i;
    end
  end

  // Valid bits and pointers
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else if (clear) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_d;
      if (resp_keep_i) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (rd.advance) begin
        rptr_q <= rptr_next;
      end
    end
  end

endmodule

//--- source/instr_aligner.sv
//////////////////////////////
// Builds 16/32-bit instructions from FIFO words; the branch
// address must be halfword aligned
//////////////////////////////

`timescale 1ns/10ps

`include "align_settings.svh"

module instr_aligner (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pc_set_i,
  input  logic                     kill_i,
  input  logic [`ALIGN_ADDR_W-1:0] branch_addr_i,
  input  logic                     resp_keep_i,
  input  align_pkg::fetch_word_u   resp_rdata_i,
  input  logic                     resp_err_i,
  input  logic                     instr_ready_i,
  fifo_read_if.aligner_side        rd,
  output logic                     instr_valid_o,
  output align_pkg::fetch_word_u   instr_o,
  output logic [`ALIGN_ADDR_W-1:0] instr_addr_o,
  output logic                     instr_err_o,
  output logic                     emit_o
);

  logic [`ALIGN_ADDR_W-1:0] addr_q;
  align_pkg::fetch_word_u   cur_word;
  align_pkg::fetch_word_u   upper_word;
  align_pkg::parcel_t       first_parcel;
  logic                     cur_err;
  logic                     upper_err;
  logic                     cur_valid;
  logic                     upper_valid;
  logic                     odd_half;
  logic                     is_compressed;
  logic                     build_valid;

  assign odd_half = addr_q[1];

  //////////////////////////////
  // Source selection

  // Head word, or the response passing straight through
  assign cur_word  = rd.head_valid ? rd.head_word : resp_rdata_i;
  assign cur_err   = rd.head_valid ? rd.head_err  : resp_err_i;
  assign cur_valid = rd.head_valid || resp_keep_i;

  // Word after the head, for straddling instructions
  assign upper_word  = rd.next_valid ? rd.next_word : resp_rdata_i;
  assign upper_err   = rd.next_valid ? rd.next_err  : resp_err_i;
  assign upper_valid = rd.next_valid || (rd.head_valid && resp_keep_i);

  // Parcel at the current halfword
  assign first_parcel  = odd_half ? cur_word.parcel.hi : cur_word.parcel.lo;
  assign is_compressed = first_parcel[1:0] != 2'b11;

  //////////////////////////////
  // Instruction build

  always_comb begin
    instr_o     = cur_word;
    instr_err_o = cur_err;
    build_valid = cur_valid;
    if (odd_half) begin
      // High parcel first, next word's low parcel on top
      instr_o.parcel.lo = cur_word.parcel.hi;
      instr_o.parcel.hi = upper_word.parcel.lo;
      if (!is_compressed) begin
        instr_err_o = cur_err || upper_err;
        build_valid = upper_valid;
      end
    end
  end

  // No output in a branch or kill cycle
  assign instr_valid_o = build_valid && !pc_set_i && !kill_i;
  assign emit_o        = instr_valid_o && instr_ready_i;

  // Head used up unless an aligned compressed leaves its high half
  assign rd.advance = emit_o && (odd_half || !is_compressed);

  assign instr_addr_o = addr_q;

  //////////////////////////////
  // Halfword address

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (pc_set_i) begin
      addr_q <= {branch_addr_i[`ALIGN_ADDR_W-1:1], 1'b0};
    end else if (emit_o) begin
      // Step by instruction length
      addr_q <= addr_q + (is_compressed ? `ALIGN_ADDR_W'(2) : `ALIGN_ADDR_W'(4));
    end
  end

endmodule

//--- source/align_buffer.sv
//////////////////////////////
// Alignment buffer top; responses must arrive in order
// and never ahead of their accepted request
//////////////////////////////

`timescale 1ns/10ps

`include "align_settings.svh"

module align_buffer (
  input  logic                     clk,
  input  logic                     rst_n,

  // Control
  input  logic                     instr_req_i,
  input  logic                     pc_set_i,
  input  logic [`ALIGN_ADDR_W-1:0] branch_addr_i,
  input  logic                     kill_i,
  output logic                     busy_o,

  // Fetch request
  output logic                     fetch_valid_o,
  input  logic                     fetch_ready_i,

  // Fetch response
  input  logic                     resp_valid_i,
  input  align_pkg::fetch_word_u   resp_rdata_i,
  input  logic                     resp_err_i,

  // Instruction output
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output align_pkg::fetch_word_u   instr_o,
  output logic [`ALIGN_ADDR_W-1:0] instr_addr_o,
  output logic                     instr_err_o
);

  // Response after flush filtering
  logic resp_keep;
  // Instruction taken this cycle
  logic emit;

  fifo_read_if rd_if ();

  fetch_ctrl i_fetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_req_i   (instr_req_i),
    .pc_set_i      (pc_set_i),
    .branch_half_i (branch_addr_i[1]),
    .kill_i        (kill_i),
    .fetch_ready_i (fetch_ready_i),
    .resp_valid_i  (resp_valid_i),
    .resp_rdata_i  (resp_rdata_i),
    .emit_i        (emit),
    .fetch_valid_o (fetch_valid_o),
    .busy_o        (busy_o),
    .resp_keep_o   (resp_keep)
  );

  word_fifo i_word_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_set_i     (pc_set_i),
    .kill_i       (kill_i),
    .resp_keep_i  (resp_keep),
    .resp_rdata_i (resp_rdata_i),
    .resp_err_i   (resp_err_i),
    .rd           (rd_if.fifo_side)
  );

  instr_aligner i_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .branch_addr_i (branch_addr_i),
    .resp_keep_i   (resp_keep),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .instr_ready_i (instr_ready_i),
    .rd            (rd_if.aligner_side),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .instr_err_o   (instr_err_o),
    .emit_o        (emit)
  );

endmodule

//--- tests/tb_clk_gen.sv
//////////////////////////////
// 10 ns clock, reset low for the first 8 cycles
//////////////////////////////

`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release just after the 8th rising edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

//--- tests/tb_align_buffer.sv
//////////////////////////////
// Alignment buffer testbench; the 64-word program image
// wraps and responses return in order
//////////////////////////////

`timescale 1ns/10ps

`include "align_settings.svh"

module tb_align_buffer;

  localparam int unsigned IMG_WORDS = 64;

  logic                     clk;
  logic                     rst_n;
  logic                     instr_req_i;
  logic                     pc_set_i;
  logic [`ALIGN_ADDR_W-1:0] branch_addr_i;
  logic                     kill_i;
  logic                     busy_o;
  logic                     fetch_valid_o;
  logic                     fetch_ready_i;
  logic                     resp_valid_i;
  align_pkg::fetch_word_u   resp_rdata_i;
  logic                     resp_err_i;
  logic                     instr_valid_o;
  logic                     instr_ready_i;
  align_pkg::fetch_word_u   instr_o;
  logic [`ALIGN_ADDR_W-1:0] instr_addr_o;
  logic                     instr_err_o;

  // Program image with one bus error flag per word
  align_pkg::fetch_word_u image [IMG_WORDS];
  logic                   err_img [IMG_WORDS];

  logic [15:0] lfsr_state = 16'd50;

  // Memory responder state
  logic [5:0]  fetch_word;
  logic [5:0]  pend_idx [$];
  int unsigned pend_due [$];
  int unsigned last_due;
  int unsigned cycle_cnt;
  int          out_cnt;
  logic        hold_resp;

  // Expected stream
  logic [`ALIGN_ADDR_W-1:0] exp_addr;
  int unsigned              take_cnt;
  logic                     quiet_check;

  tb_clk_gen i_tb_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  align_buffer i_align_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_req_i   (instr_req_i),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr_i),
    .kill_i        (kill_i),
    .busy_o        (busy_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .resp_valid_i  (resp_valid_i),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .instr_err_o   (instr_err_o)
  );

  //////////////////////////////
  // Random source

  // Galois LFSR stepped once per bit
  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_step()};
    end
    return val;
  endfunction

  // Words 0-7 hold only 32-bit instructions and the rest is mixed
  // Word 40 starts a straddler whose second word alone is faulty
  task automatic fill_image();
    for (int w = 0; w < IMG_WORDS; w++) begin
      image[w]   = rand_bits(32);
      err_img[w] = 1'b0;
      if (w < 8) begin
        image[w].parcel.lo[1:0] = 2'b11;
      end else if (w % 3 == 0) begin
        image[w].parcel.hi[1:0] = 2'b11;
      end else if (w % 3 == 1) begin
        image[w].parcel.lo[1:0] = 2'b00;
      end
    end
    image[40].parcel.hi[1:0] = 2'b11;
    err_img[41] = 1'b1;
    err_img[50] = 1'b1;
  endtask

  //////////////////////////////
  // Reference and checks

  // Instruction at a halfword address with its error and the next address
  function automatic void ref_instr(
    input  logic [`ALIGN_ADDR_W-1:0] addr,
    output align_pkg::fetch_word_u   instr,
    output logic                     err,
    output logic                     is32,
    output logic [`ALIGN_ADDR_W-1:0] next_addr
  );
    logic [5:0]         idx;
    align_pkg::parcel_t first;
    align_pkg::parcel_t second;
    idx    = addr[7:2];
    first  = addr[1] ? image[idx].parcel.hi : image[idx].parcel.lo;
    second = addr[1] ? image[idx + 6'd1].parcel.lo : image[idx].parcel.hi;
    // Low bits 11 mark a 32-bit instruction
    is32 = (first[1:0] == 2'b11);
    instr.parcel.lo = first;
    instr.parcel.hi = second;
    err = err_img[idx];
    if (is32 && addr[1]) begin
      err = err | err_img[idx + 6'd1];
    end
    next_addr = addr + (is32 ? `ALIGN_ADDR_W'(4) : `ALIGN_ADDR_W'(2));
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  // Compressed instructions only define the low parcel
  task automatic check_instr(input align_pkg::fetch_word_u exp_val,
                             input align_pkg::fetch_word_u got_val,
                             input logic                   is32);
    if (is32 && (got_val.instr !== exp_val.instr)) begin
      fail_run($sformatf("FAILED instr_o exp 0x%h got 0x%h",
                         exp_val.instr, got_val.instr));
    end else if (!is32 && (got_val.parcel.lo !== exp_val.parcel.lo)) begin
      fail_run($sformatf("FAILED instr_o[15:0] exp 0x%h got 0x%h",
                         exp_val.parcel.lo, got_val.parcel.lo));
    end
  endtask

  task automatic check_addr(input logic [`ALIGN_ADDR_W-1:0] exp_val,
                            input logic [`ALIGN_ADDR_W-1:0] got_val);
    if (got_val !== exp_val) begin
      fail_run($sformatf("FAILED instr_addr_o exp 0x%h got 0x%h", exp_val, got_val));
    end
  endtask

  task automatic check_err(input logic exp_val, input logic got_val);
    if (got_val !== exp_val) begin
      fail_run($sformatf("FAILED instr_err_o exp 0x%h got 0x%h", exp_val, got_val));
    end
  endtask

  //////////////////////////////
  // Memory responder

  // Record accepted requests mid-cycle with a due cycle 1 to 3 later
  always @(negedge clk) begin : accept_proc
    int unsigned due;
    if (rst_n) begin
      // Request in the branch cycle already targets the new word
      if (pc_set_i) begin
        fetch_word = branch_addr_i[7:2];
      end
      if (fetch_valid_o && fetch_ready_i) begin
        due = cycle_cnt + 1 + (rand_bits(2) % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        pend_idx.push_back(fetch_word);
        pend_due.push_back(due);
        last_due   = due;
        fetch_word = fetch_word + 6'd1;
        out_cnt++;
      end
      if (resp_valid_i) begin
        out_cnt--;
      end
      if (out_cnt > `ALIGN_MAX_OUTSTANDING) begin
        fail_run("more than two fetch requests in flight");
      end
    end
  end

  // One response per cycle with the oldest first
  always @(posedge clk) begin
    cycle_cnt++;
    #1;
    if (!hold_resp && (pend_due.size() != 0) && (pend_due[0] <= cycle_cnt)) begin
      resp_valid_i = 1'b1;
      resp_rdata_i = image[pend_idx[0]];
      resp_err_i   = err_img[pend_idx[0]];
      pend_idx.delete(0);
      pend_due.delete(0);
    end else begin
      resp_valid_i = 1'b0;
      resp_rdata_i = '0;
      resp_err_i   = 1'b0;
    end
  end

  //////////////////////////////
  // Compare process

  always @(negedge clk) begin : compare_proc
    align_pkg::fetch_word_u   e_instr;
    logic                     e_err;
    logic                     e_is32;
    logic [`ALIGN_ADDR_W-1:0] e_next;
    if (rst_n) begin
      if (pc_set_i) begin
        exp_addr = branch_addr_i;
      end else if (instr_valid_o && instr_ready_i) begin
        ref_instr(exp_addr, e_instr, e_err, e_is32, e_next);
        check_addr(exp_addr, instr_addr_o);
        check_instr(e_instr, instr_o, e_is32);
        check_err(e_err, instr_err_o);
        exp_addr = e_next;
        take_cnt++;
      end
      if (quiet_check && instr_valid_o) begin
        fail_run("instr_valid_o went high after kill with fetching off");
      end
    end
  end

  //////////////////////////////
  // Stimulus helpers

  // One-cycle branch strobe with fetching enabled
  task automatic branch_to(input logic [`ALIGN_ADDR_W-1:0] addr);
    @(posedge clk);
    #1;
    instr_req_i   = 1'b1;
    pc_set_i      = 1'b1;
    branch_addr_i = addr;
    @(posedge clk);
    #1;
    pc_set_i = 1'b0;
  endtask

  // Changed mid-cycle so the responder sees it on the next edge
  task automatic set_hold(input logic val);
    @(negedge clk);
    hold_resp = val;
  endtask

  // Wait for n more takes with optional random ready
  task automatic take_more(input int n, input logic rand_ready);
    int unsigned target;
    int          waited;
    target = take_cnt + n;
    waited = 0;
    while (take_cnt < target) begin
      @(posedge clk);
      #1;
      instr_ready_i = rand_ready ? rand_bits(1) : 1'b1;
      fetch_ready_i = rand_ready ? (rand_bits(2) != 0) : 1'b1;
      waited++;
      if (waited > 40 * n + 100) begin
        fail_run("timeout waiting for instructions");
      end
    end
  endtask

  task automatic wait_outstanding(input int n);
    int waited;
    waited = 0;
    while (out_cnt < n) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > 50) begin
        fail_run("timeout waiting for requests in flight");
      end
    end
  endtask

  // Busy must stay up while anything is owed
  task automatic wait_idle();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > 50) begin
        fail_run("timeout waiting for busy_o to fall");
      end
    end while (busy_o);
    if (out_cnt != 0) begin
      fail_run("busy_o fell with responses still owed");
    end
  endtask

  //////////////////////////////
  // Test sequence

  initial begin : main_proc
    int waited;
    instr_req_i   = 1'b0;
    pc_set_i      = 1'b0;
    branch_addr_i = '0;
    kill_i        = 1'b0;
    fetch_ready_i = 1'b1;
    resp_valid_i  = 1'b0;
    resp_rdata_i  = '0;
    resp_err_i    = 1'b0;
    instr_ready_i = 1'b1;
    fetch_word    = '0;
    last_due      = 0;
    cycle_cnt     = 0;
    out_cnt       = 0;
    hold_resp     = 1'b0;
    exp_addr      = '0;
    take_cnt      = 0;
    quiet_check   = 1'b0;
    fill_image();

    waited = 0;
    while (!rst_n) begin
      @(posedge clk);
      waited++;
      if (waited > 20) begin
        fail_run("reset never released");
      end
    end
    #2;
    if (busy_o || instr_valid_o || fetch_valid_o) begin
      fail_run("outputs active right after reset");
    end

    // Aligned 32-bit stream from word 0
    branch_to(32'h0000_0000);
    take_more(8, 1'b0);

    // Mixed stream with straddlers
    branch_to(32'h0000_0020);
    take_more(40, 1'b0);

    // Odd halfword target
    branch_to(32'h0000_0062);
    take_more(10, 1'b0);

    // Branch away while two responses are held back
    instr_ready_i = 1'b0;
    set_hold(1'b1);
    branch_to(32'h0000_0030);
    wait_outstanding(2);
    branch_to(32'h0000_00e0);
    set_hold(1'b0);
    take_more(12, 1'b0);

    // Bus errors on a straddler and then on an aligned faulty word
    branch_to(32'h0000_00a2);
    take_more(10, 1'b0);
    branch_to(32'h0000_00c8);
    take_more(6, 1'b0);

    // Random back-pressure on both handshakes
    branch_to(32'h0000_0040);
    take_more(60, 1'b1);

    // Kill with responses owed and fetching off
    instr_ready_i = 1'b0;
    fetch_ready_i = 1'b1;
    set_hold(1'b1);
    branch_to(32'h0000_0010);
    wait_outstanding(2);
    @(posedge clk);
    #1;
    kill_i      = 1'b1;
    instr_req_i = 1'b0;
    @(posedge clk);
    #1;
    kill_i      = 1'b0;
    quiet_check = 1'b1;
    set_hold(1'b0);
    wait_idle();

    // Short quiet window after the drain
    repeat (10) begin
      @(posedge clk);
      #2;
      if (busy_o || fetch_valid_o) begin
        fail_run("fetch activity after kill with fetching off");
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
source/align_pkg.sv
source/fifo_read_if.sv
source/fetch_ctrl.sv
source/word_fifo.sv
source/instr_aligner.sv
source/align_buffer.sv
tests/tb_clk_gen.sv
tests/tb_align_buffer.sv

//--- Bender.yml
package:
  name: align_buffer

sources:
  - include_dirs:
      - include
    files:
      - source/align_pkg.sv
      - source/fifo_read_if.sv
      - source/fetch_ctrl.sv
      - source/word_fifo.sv
      - source/instr_aligner.sv
      - source/align_buffer.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_align_buffer.sv
